// File: rtl/ipod_pkg.sv
package ipod_pkg;

  // ==========================================================
  // Flash memory port
  // ==========================================================

  // Word address into the song area
  localparam int flash_addr_w = 23;

  // One flash word carries two samples
  localparam int flash_data_w = 32;

  // Lower half is the earlier sample in forward play
  localparam int sample_w = 16;

  // Only the top byte of a sample reaches the codec
  localparam int audio_w = 8;

  // ==========================================================
  // Sample period, in CLK_50M cycles
  // ==========================================================

  localparam int period_w = 16;
  localparam int min_sample_period = 16;
  localparam int max_sample_period = 60000;

  // ==========================================================
  // Push buttons
  // ==========================================================

  localparam int num_keys = 4;

  // Bit positions in the key vector
  localparam int key_speed_up = 0;
  localparam int key_speed_down = 1;
  localparam int key_speed_reset = 2;
  localparam int key_restart = 3;

endpackage

// File: rtl/key_event_conditioner.sv
module key_event_conditioner #(
  parameter int unsigned key_repeat_cycles = 5_000_000
) (
  input  logic                          CLK_50M,
  input  logic                          reset,
  input  logic [ipod_pkg::num_keys-1:0] keys,
  output logic                          speed_up,
  output logic                          speed_down,
  output logic                          speed_reset,
  output logic                          restart
);

  localparam int nk = ipod_pkg::num_keys;
  localparam int rep_w = (key_repeat_cycles > 2) ? $clog2(key_repeat_cycles) : 1;

  // Only the speed keys auto-repeat
  localparam logic [nk-1:0] speed_mask =
    nk'((1 << ipod_pkg::key_speed_up) | (1 << ipod_pkg::key_speed_down));

  logic [nk-1:0]    key_meta;
  logic [nk-1:0]    key_sync;
  logic [nk-1:0]    key_prev;
  logic [nk-1:0]    press;
  logic [nk-1:0]    held_speed;
  logic [nk-1:0]    repeat_hit;
  logic [nk-1:0]    pulse_q;
  logic [rep_w-1:0] rep_cnt;
  logic             speed_press;
  logic             rep_fire;

  // Buttons are active low, flip them in the first stage
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta <= '0;
      key_sync <= '0;
      key_prev <= '0;
    end
    else
    begin
      key_meta <= ~keys;
      key_sync <= key_meta;
      key_prev <= key_sync;
    end
  end

  assign press       = key_sync & ~key_prev;
  assign held_speed  = key_sync & speed_mask;
  assign speed_press = |(press & speed_mask);

  // Shared interval counter, restarted by every new speed press
  assign rep_fire = (held_speed != '0) && !speed_press &&
                    (rep_cnt == rep_w'(key_repeat_cycles - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      rep_cnt <= '0;
    else if ((held_speed == '0) || speed_press || rep_fire)
      rep_cnt <= '0;
    else
      rep_cnt <= rep_cnt + 1'b1;
  end

  assign repeat_hit = held_speed & {nk{rep_fire}};

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      pulse_q <= '0;
    else
      pulse_q <= press | repeat_hit;
  end

  assign speed_up    = pulse_q[ipod_pkg::key_speed_up];
  assign speed_down  = pulse_q[ipod_pkg::key_speed_down];
  assign speed_reset = pulse_q[ipod_pkg::key_speed_reset];
  assign restart     = pulse_q[ipod_pkg::key_restart];

  // Press edge and repeat timer must never merge into a long pulse
  a_single_cycle_pulses: assert property (
    @(posedge CLK_50M) disable iff (reset)
    (pulse_q & $past(pulse_q)) == '0
  ) else $error("key event held high for two cycles");

endmodule

// File: rtl/sample_rate_control.sv
module sample_rate_control #(
  parameter int unsigned base_sample_period = 2272,
  parameter int unsigned speed_step = 100
) (
  input  logic                          CLK_50M,
  input  logic                          reset,
  input  logic                          speed_up,
  input  logic                          speed_down,
  input  logic                          speed_reset,
  output logic [ipod_pkg::period_w-1:0] sample_period,
  output logic                          sample_tick
);

  localparam int pw = ipod_pkg::period_w;

  // One spare bit so the sums below cannot wrap
  localparam logic [pw:0]   step_ext    = (pw + 1)'(speed_step);
  localparam logic [pw:0]   min_ext     = (pw + 1)'(ipod_pkg::min_sample_period);
  localparam logic [pw:0]   max_ext     = (pw + 1)'(ipod_pkg::max_sample_period);
  localparam logic [pw-1:0] base_period = pw'(base_sample_period);

  logic [pw-1:0] period_q;
  logic [pw-1:0] tick_cnt;
  logic [pw:0]   period_ext;
  logic [pw:0]   shorter;
  logic [pw:0]   longer;
  logic          tick_q;

  assign period_ext = {1'b0, period_q};

  // Saturating steps
  always_comb
  begin
    if (period_ext < min_ext + step_ext)
      shorter = min_ext;
    else
      shorter = period_ext - step_ext;
    if (period_ext + step_ext > max_ext)
      longer = max_ext;
    else
      longer = period_ext + step_ext;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      period_q <= base_period;
    else if (speed_reset)
      period_q <= base_period;
    else if (speed_up)
      period_q <= shorter[pw-1:0];
    else if (speed_down)
      period_q <= longer[pw-1:0];
  end

  // Down-counter picks up a new period only at reload
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      tick_cnt <= base_period - 1'b1;
      tick_q   <= 1'b0;
    end
    else if (tick_cnt == '0)
    begin
      tick_cnt <= period_q - 1'b1;
      tick_q   <= 1'b1;
    end
    else
    begin
      tick_cnt <= tick_cnt - 1'b1;
      tick_q   <= 1'b0;
    end
  end

  assign sample_period = period_q;
  assign sample_tick   = tick_q;

  a_period_in_range: assert property (
    @(posedge CLK_50M) disable iff (reset)
    ({1'b0, period_q} >= min_ext) && ({1'b0, period_q} <= max_ext)
  ) else $error("sample period outside limits");

endmodule

// File: rtl/flash_sample_reader.sv
module flash_sample_reader #(
  parameter int unsigned song_last_addr = 'h7FFFF
) (
  input  logic                              CLK_50M,
  input  logic                              reset,
  input  logic                              sample_tick,
  input  logic                              play_backward,
  input  logic                              restart,
  input  logic                              flash_waitrequest,
  input  logic [ipod_pkg::flash_data_w-1:0] flash_readdata,
  input  logic                              flash_readdatavalid,
  input  logic                              space_available,
  output logic                              flash_read,
  output logic [ipod_pkg::flash_addr_w-1:0] flash_address,
  output logic                              sample_valid,
  output logic [ipod_pkg::audio_w-1:0]      sample_byte
);

  localparam int aw = ipod_pkg::flash_addr_w;
  localparam logic [aw-1:0] last_addr = aw'(song_last_addr);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait_data
  } state_t;

  state_t state;

  logic [aw-1:0]                     addr_q;
  logic [aw-1:0]                     next_addr;
  logic [ipod_pkg::flash_data_w-1:0] word_q;
  logic [ipod_pkg::audio_w-1:0]      byte_q;
  // Low while the first half of the current word is still to play
  logic                              half_q;
  logic                              pending_q;
  logic                              restart_q;
  logic                              valid_q;
  logic                              start;
  logic                              load_word;
  logic                              serve_stored;

  // Top byte of the chosen half-word
  function automatic logic [ipod_pkg::audio_w-1:0] pick_byte(
    input logic [ipod_pkg::flash_data_w-1:0] word,
    input logic                              upper
  );
    logic [ipod_pkg::sample_w-1:0] sample;
    if (upper)
      sample = word[ipod_pkg::sample_w +: ipod_pkg::sample_w];
    else
      sample = word[0 +: ipod_pkg::sample_w];
    return sample[ipod_pkg::sample_w-1 -: ipod_pkg::audio_w];
  endfunction

  // No start while a byte is being handed over, so space_available is current
  assign start = (state == st_idle) && (sample_tick || pending_q) && space_available &&
                 !valid_q && !(restart || restart_q);
  assign serve_stored = start && half_q;
  assign load_word    = (state == st_wait_data) && flash_readdatavalid;

  always_comb
  begin
    if (play_backward)
      next_addr = (addr_q == '0) ? last_addr : addr_q - 1'b1;
    else
      next_addr = (addr_q == last_addr) ? '0 : addr_q + 1'b1;
  end

  // ==========================================================
  // Read FSM
  // ==========================================================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state     <= st_idle;
      addr_q    <= '0;
      half_q    <= 1'b0;
      pending_q <= 1'b0;
      restart_q <= 1'b0;
      valid_q   <= 1'b0;
    end
    else
    begin
      valid_q   <= 1'b0;
      // One tick is remembered while busy, any more are dropped
      pending_q <= (pending_q || sample_tick) && !start;
      case (state)
        st_idle:
        begin
          if (restart || restart_q)
          begin
            addr_q    <= play_backward ? last_addr : '0;
            half_q    <= 1'b0;
            restart_q <= 1'b0;
          end
          else if (start && !half_q)
            state <= st_request;
          else if (serve_stored)
          begin
            valid_q <= 1'b1;
            half_q  <= 1'b0;
            addr_q  <= next_addr;
          end
        end
        st_request:
        begin
          if (restart)
            restart_q <= 1'b1;
          if (!flash_waitrequest)
            state <= st_wait_data;
        end
        st_wait_data:
        begin
          if (restart)
            restart_q <= 1'b1;
          if (flash_readdatavalid)
          begin
            valid_q <= 1'b1;
            half_q  <= 1'b1;
            state   <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // First half is the upper one when playing backward
  always_ff @(posedge CLK_50M)
  begin
    if (load_word)
    begin
      word_q <= flash_readdata;
      byte_q <= pick_byte(flash_readdata, play_backward);
    end
    else if (serve_stored)
      byte_q <= pick_byte(word_q, !play_backward);
  end

  assign flash_read    = (state == st_request);
  assign flash_address = addr_q;
  assign sample_valid  = valid_q;
  assign sample_byte   = byte_q;

  a_addr_held_while_waiting: assert property (
    @(posedge CLK_50M) disable iff (reset)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address)
  ) else $error("flash command changed before acceptance");

endmodule

// File: rtl/audio_sample_output.sv
module audio_sample_output (
  input  logic                         CLK_50M,
  input  logic                         reset,
  input  logic                         sample_valid,
  input  logic [ipod_pkg::audio_w-1:0] sample_byte,
  input  logic                         audio_ready,
  output logic                         space_available,
  output logic                         audio_valid,
  output logic [ipod_pkg::audio_w-1:0] audio_data
);

  logic [ipod_pkg::audio_w-1:0] buf_mem [2];
  logic                         wr_ptr;
  logic                         rd_ptr;
  logic [1:0]                   count;
  logic                         push;
  logic                         pop;

  assign push = sample_valid;
  assign pop  = audio_valid && audio_ready;

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr <= ~wr_ptr;
      if (pop)
        rd_ptr <= ~rd_ptr;
      count <= count + 2'(push) - 2'(pop);
    end
  end

  // Writes never land on the entry being offered
  always_ff @(posedge CLK_50M)
  begin
    if (push)
      buf_mem[wr_ptr] <= sample_byte;
  end

  assign audio_valid     = (count != 2'd0);
  assign space_available = (count != 2'd2);
  assign audio_data      = buf_mem[rd_ptr];

  a_no_write_when_full: assert property (
    @(posedge CLK_50M) disable iff (reset)
    sample_valid |-> count != 2'd2
  ) else $error("sample arrived with the output buffer full");

  a_data_held_under_backpressure: assert property (
    @(posedge CLK_50M) disable iff (reset)
    audio_valid && !audio_ready |=> audio_valid && $stable(audio_data)
  ) else $error("audio byte changed while waiting for ready");

endmodule

// File: rtl/ipod_player_top.sv
module ipod_player_top #(
  parameter int unsigned song_last_addr = 'h7FFFF,
  parameter int unsigned base_sample_period = 2272,
  parameter int unsigned speed_step = 100,
  parameter int unsigned key_repeat_cycles = 5_000_000
) (
  input  logic                              CLK_50M,
  input  logic                              reset,
  input  logic [ipod_pkg::num_keys-1:0]     keys,
  input  logic                              play_backward,
  input  logic                              flash_waitrequest,
  input  logic [ipod_pkg::flash_data_w-1:0] flash_readdata,
  input  logic                              flash_readdatavalid,
  input  logic                              audio_ready,
  output logic                              flash_read,
  output logic [ipod_pkg::flash_addr_w-1:0] flash_address,
  output logic [ipod_pkg::audio_w-1:0]      audio_data,
  output logic                              audio_valid,
  output logic [ipod_pkg::period_w-1:0]     sample_period
);

  logic                         speed_up;
  logic                         speed_down;
  logic                         speed_reset;
  logic                         restart;
  logic                         sample_tick;
  logic                         sample_valid;
  logic [ipod_pkg::audio_w-1:0] sample_byte;
  logic                         space_available;

  key_event_conditioner #(
    .key_repeat_cycles (key_repeat_cycles)
  ) u_keys (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .keys        (keys),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .restart     (restart)
  );

  sample_rate_control #(
    .base_sample_period (base_sample_period),
    .speed_step         (speed_step)
  ) u_rate (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .speed_up      (speed_up),
    .speed_down    (speed_down),
    .speed_reset   (speed_reset),
    .sample_period (sample_period),
    .sample_tick   (sample_tick)
  );

  flash_sample_reader #(
    .song_last_addr (song_last_addr)
  ) u_reader (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .sample_tick         (sample_tick),
    .play_backward       (play_backward),
    .restart             (restart),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .space_available     (space_available),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .sample_valid        (sample_valid),
    .sample_byte         (sample_byte)
  );

  audio_sample_output u_audio (
    .CLK_50M         (CLK_50M),
    .reset           (reset),
    .sample_valid    (sample_valid),
    .sample_byte     (sample_byte),
    .audio_ready     (audio_ready),
    .space_available (space_available),
    .audio_valid     (audio_valid),
    .audio_data      (audio_data)
  );

endmodule

// File: verification/tb_flash_model.sv
module tb_flash_model (
  input  logic                              CLK_50M,
  input  logic                              reset,
  input  logic                              flash_read,
  input  logic [ipod_pkg::flash_addr_w-1:0] flash_address,
  output logic                              flash_waitrequest,
  output logic [ipod_pkg::flash_data_w-1:0] flash_readdata,
  output logic                              flash_readdatavalid
);

  timeunit 1ns;
  timeprecision 100ps;

  logic                              busy;
  logic [1:0]                        delay;
  logic [ipod_pkg::flash_addr_w-1:0] addr_q;

  // Song content, a fixed mix of the word address
  function automatic logic [ipod_pkg::flash_data_w-1:0] word_at(
    input logic [ipod_pkg::flash_addr_w-1:0] addr
  );
    logic [31:0] a;
    a = 32'(addr);
    return (a * 32'h9e37_79b9) ^ {a[15:0], a[15:0]} ^ 32'h5a5a_c3c3;
  endfunction

  initial
  begin
    flash_waitrequest   = 1'b1;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
  end

  // One read at a time, data 1 to 4 cycles after acceptance
  always @(posedge CLK_50M)
  begin
    if (reset)
    begin
      busy                <= 1'b0;
      delay               <= 2'd0;
      flash_waitrequest   <= 1'b1;
      flash_readdatavalid <= 1'b0;
    end
    else
    begin
      flash_readdatavalid <= 1'b0;
      flash_waitrequest   <= ($urandom % 2) == 0;
      if (busy)
      begin
        if (delay == 2'd0)
        begin
          busy                <= 1'b0;
          flash_readdata      <= word_at(addr_q);
          flash_readdatavalid <= 1'b1;
        end
        else
          delay <= delay - 2'd1;
      end
      else if (flash_read && !flash_waitrequest)
      begin
        busy   <= 1'b1;
        addr_q <= flash_address;
        delay  <= 2'($urandom % 4);
      end
    end
  end

endmodule

// File: verification/tb_ipod_player.sv
module tb_ipod_player;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int song_last_addr = 15;
  localparam int base_sample_period = 40;
  localparam int speed_step = 8;
  localparam int key_repeat_cycles = 64;
  localparam int num_samples = 2 * (song_last_addr + 1);
  localparam int capture_len = 10;
  // Two buffered, one in flight, one accepted before the pulse lands
  localparam int max_old_bytes = 4;
  localparam int down_hold = 6 * key_repeat_cycles + 32;
  localparam int up_hold = 14 * key_repeat_cycles + 32;
  // Per byte one period and a slow fetch, with the back-pressure test counted four times
  localparam int byte_cycles = base_sample_period + 20;
  localparam int cycle_limit = 2 * ((40 + 2 * capture_len + 36 + 13 + 4 * 40) * byte_cycles
                                   + 200 + down_hold + up_hold + 500);

  logic                              CLK_50M;
  logic                              reset;
  logic [ipod_pkg::num_keys-1:0]     keys;
  logic                              play_backward;
  logic                              audio_ready;
  logic                              flash_waitrequest;
  logic [ipod_pkg::flash_data_w-1:0] flash_readdata;
  logic                              flash_readdatavalid;
  logic                              flash_read;
  logic [ipod_pkg::flash_addr_w-1:0] flash_address;
  logic [ipod_pkg::audio_w-1:0]      audio_data;
  logic                              audio_valid;
  logic [ipod_pkg::period_w-1:0]     sample_period;

  int                           errors = 0;
  int                           errors_before = 0;
  int                           checks = 0;
  int                           tests_run = 0;
  int                           tests_failed = 0;
  int                           cycle_count = 0;
  int                           accepted = 0;
  int                           pos = 0;
  int                           old_pos = 0;
  int                           split;
  bit                           exp_backward = 1'b0;
  bit                           old_backward = 1'b0;
  bit                           capturing = 1'b0;
  bit                           was_waiting = 1'b0;
  bit                           read_open = 1'b0;
  logic [ipod_pkg::audio_w-1:0] held_data;
  logic [ipod_pkg::audio_w-1:0] captured [$];

  ipod_player_top #(
    .song_last_addr     (song_last_addr),
    .base_sample_period (base_sample_period),
    .speed_step         (speed_step),
    .key_repeat_cycles  (key_repeat_cycles)
  ) DUT (.*);

  tb_flash_model flash (.*);

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ==========================================================
  // Reference model
  // ==========================================================

  function automatic logic [ipod_pkg::audio_w-1:0] expected_byte(input int position,
                                                                  input bit backward);
    int                                slot;
    int                                word_idx;
    bit                                upper;
    logic [ipod_pkg::flash_data_w-1:0] word;
    slot = position % num_samples;
    word_idx = backward ? song_last_addr - slot / 2 : slot / 2;
    // Forward starts each word with the lower half and backward with the upper
    upper = (slot % 2 == 1) != backward;
    word = flash.word_at(ipod_pkg::flash_addr_w'(word_idx));
    return upper ? word[31:24] : word[15:8];
  endfunction

  // Step first, then clamp to the allowed period range
  function automatic int apply_steps(input int period, input bit longer, input int n);
    int i;
    for (i = 0; i < n; i++)
    begin
      period = longer ? period + speed_step : period - speed_step;
      if (period < ipod_pkg::min_sample_period)
        period = ipod_pkg::min_sample_period;
      if (period > ipod_pkg::max_sample_period)
        period = ipod_pkg::max_sample_period;
    end
    return period;
  endfunction

  // Number of old bytes that drain before the new order starts
  function automatic int restart_split();
    int k;
    int i;
    bit ok;
    for (k = 0; k <= max_old_bytes; k++)
    begin
      ok = 1'b1;
      for (i = 0; i < capture_len; i++)
      begin
        if (i < k)
          ok = ok && (captured[i] == expected_byte(old_pos + i, old_backward));
        else
          ok = ok && (captured[i] == expected_byte(i - k, exp_backward));
      end
      if (ok)
        return k;
    end
    return -1;
  endfunction

  task automatic log_error(input string msg);
    errors++;
    $display("FAILED at %0t: %s", $time, msg);
  endtask

  // ==========================================================
  // Output checker
  // ==========================================================

  always @(posedge CLK_50M)
  begin
    if (!reset)
    begin
      if (was_waiting)
      begin
        checks++;
        assert (audio_valid && audio_data == held_data)
          else log_error($sformatf("audio byte moved from %0h to %0h while stalled",
                                   held_data, audio_data));
      end
      if (audio_valid && audio_ready)
      begin
        accepted++;
        if (capturing)
        begin
          captured.push_back(audio_data);
          if (captured.size() == capture_len)
          begin
            split = restart_split();
            checks++;
            assert (split >= 0)
              else log_error("bytes after restart fit neither the old nor the new order");
            pos = (split >= 0) ? capture_len - split : capture_len;
            capturing = 1'b0;
          end
        end
        else
        begin
          checks++;
          assert (audio_data == expected_byte(pos, exp_backward))
            else log_error($sformatf("byte %0d is %0h, expected %0h", pos, audio_data,
                                     expected_byte(pos, exp_backward)));
          pos++;
        end
      end
      was_waiting = audio_valid && !audio_ready;
      held_data = audio_data;
    end
  end

  // Only one flash read may be outstanding
  always @(posedge CLK_50M)
  begin
    if (reset)
      read_open = 1'b0;
    else
    begin
      if (flash_read)
      begin
        checks++;
        assert (!read_open)
          else log_error("flash read issued while another read was outstanding");
      end
      if (flash_read && !flash_waitrequest)
        read_open = 1'b1;
      else if (flash_readdatavalid)
        read_open = 1'b0;
    end
  end

  // ==========================================================
  // Stimulus helpers
  // ==========================================================

  task automatic press_key(input int idx, input int hold);
    @(posedge CLK_50M);
    keys[idx] <= 1'b0;
    repeat (hold) @(posedge CLK_50M);
    keys[idx] <= 1'b1;
    repeat (8) @(posedge CLK_50M);
  endtask

  task automatic check_period(input int expected, input string what);
    checks++;
    assert (int'(sample_period) == expected)
      else log_error($sformatf("%s gave period %0d, expected %0d", what, sample_period, expected));
  endtask

  // Every move is one clamped step and the end value follows the repeat count
  task automatic hold_and_track(input int idx, input int hold, input bit longer);
    int start;
    int prev;
    int c;
    start = int'(sample_period);
    prev = start;
    @(posedge CLK_50M);
    keys[idx] <= 1'b0;
    for (c = 0; c < hold + 8; c++)
    begin
      @(posedge CLK_50M);
      if (c == hold - 1)
        keys[idx] <= 1'b1;
      if (int'(sample_period) != prev)
      begin
        checks++;
        assert (int'(sample_period) == apply_steps(prev, longer, 1))
          else log_error($sformatf("period jumped from %0d to %0d", prev, sample_period));
        prev = int'(sample_period);
      end
    end
    check_period(apply_steps(start, longer, 1 + (hold - 3) / key_repeat_cycles), "held key");
  endtask

  task automatic wait_bytes(input int count);
    int target;
    target = accepted + count;
    while (accepted < target)
      @(negedge CLK_50M);
  endtask

  task automatic begin_capture(input bit new_backward);
    @(negedge CLK_50M);
    old_pos = pos;
    old_backward = exp_backward;
    exp_backward = new_backward;
    captured.delete();
    capturing = 1'b1;
  endtask

  task automatic wait_capture();
    while (capturing)
      @(negedge CLK_50M);
  endtask

  // Random ready level in stretches of up to 120 cycles
  task automatic backpressure_run(input int count);
    int target;
    int stretch;
    target = accepted + count;
    stretch = 0;
    while (accepted < target)
    begin
      @(posedge CLK_50M);
      if (stretch == 0)
      begin
        audio_ready <= ($urandom % 2) == 0;
        stretch = 1 + ($urandom % 120);
      end
      stretch--;
      @(negedge CLK_50M);
    end
    @(posedge CLK_50M);
    audio_ready <= 1'b1;
  endtask

  task automatic end_test(input string name);
    @(negedge CLK_50M);
    tests_run++;
    if (errors == errors_before)
      $display("Test %0d, %s: passed", tests_run, name);
    else
    begin
      tests_failed++;
      $display("Test %0d, %s: failed with %0d errors", tests_run, name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  // ==========================================================
  // Test sequence
  // ==========================================================

  initial
  begin
    void'($urandom(32'h53fc_3635));
    reset         = 1'b1;
    keys          = '1;
    play_backward = 1'b0;
    audio_ready   = 1'b1;
    repeat (3) @(posedge CLK_50M);
    reset <= 1'b0;

    wait_bytes(40);
    end_test("forward play");

    // Stall output so the reader is idle when the direction flips
    begin_capture(1'b1);
    @(posedge CLK_50M);
    audio_ready <= 1'b0;
    repeat (200) @(posedge CLK_50M);
    play_backward <= 1'b1;
    press_key(ipod_pkg::key_restart, 5);
    audio_ready <= 1'b1;
    wait_capture();
    wait_bytes(36);
    end_test("backward play");

    backpressure_run(40);
    end_test("back-pressure");

    repeat (3) press_key(ipod_pkg::key_speed_up, 5);
    check_period(apply_steps(base_sample_period, 1'b0, 3), "three speed-up presses");
    press_key(ipod_pkg::key_speed_reset, 5);
    check_period(base_sample_period, "speed reset");
    hold_and_track(ipod_pkg::key_speed_down, down_hold, 1'b1);
    hold_and_track(ipod_pkg::key_speed_up, up_hold, 1'b0);
    press_key(ipod_pkg::key_speed_reset, 5);
    check_period(base_sample_period, "second speed reset");
    end_test("speed keys");

    wait_bytes(7);
    begin_capture(exp_backward);
    press_key(ipod_pkg::key_restart, 5);
    wait_capture();
    wait_bytes(6);
    end_test("restart");

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  initial
  begin
    while (cycle_count < cycle_limit)
    begin
      @(posedge CLK_50M);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Something failed");
    $finish;
  end

endmodule

// File: compile.f
rtl/ipod_pkg.sv
rtl/key_event_conditioner.sv
rtl/sample_rate_control.sv
rtl/flash_sample_reader.sv
rtl/audio_sample_output.sv
rtl/ipod_player_top.sv
verification/tb_flash_model.sv
verification/tb_ipod_player.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f compile.f --top-module tb_ipod_player -Mdir obj_dir -o sim_ipod_player
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_ipod_player)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
  exit 0
fi
echo "Pass message not found"
exit 1
